//--- Makefile
# Verilator build and run for the issue stage

TOP = issue_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f issue_stage.f \
		--top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing --assert -f issue_stage.f \
		--top-module issue_stage

clean:
	rm -rf obj_dir

//--- common/issue_params.svh
// ========================================
// Issue stage sizing macros
// Queue depth, lane count, unit count
// ========================================
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// Entries held by each unit FIFO
`define ISSUE_FIFO_DEPTH 4

// Issue lanes per cycle, also the free-slot ceiling
`define ISSUE_WIDTH 2

// ALU0, ALU1, ALU2, MUL, LOAD, BRANCH
`define ISSUE_FU_NUM 6

`endif

//--- common/issue_pkg.sv
// ========================================
// Issue stage shared types
// Instruction union, packet, unit classes
// ========================================
`include "issue_params.svh"

package issue_pkg;

    // ========================================
    // Instruction word
    // ========================================
    // R-type layout, funct7 valid for OP
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // I-type layout, upper bits are immediate
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // Same 32 bits seen both ways
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_word_u;

    // Major opcodes the steerer cares about
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // M-extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // ========================================
    // Packet and unit classes
    // ========================================
    // 69 bits: pc, ROB tag, instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rob_tag;
        instr_word_u instr;
    } issue_packet_t;

    typedef enum logic [1:0] {
        CLASS_ALU,
        CLASS_MUL,
        CLASS_LOAD,
        CLASS_BRANCH
    } fu_class_e;

    // Unit FIFO positions
    localparam int FU_ALU0   = 0;
    localparam int FU_ALU1   = 1;
    localparam int FU_ALU2   = 2;
    localparam int FU_MUL    = 3;
    localparam int FU_LOAD   = 4;
    localparam int FU_BRANCH = 5;

    // Saturated free-slot count, 0 to ISSUE_WIDTH
    typedef logic [$clog2(`ISSUE_WIDTH+1)-1:0] slot_cnt_t;

endpackage

//--- fu_fifo/fu_fifo.sv
// ========================================
// Per-unit issue FIFO
// Circular buffer, combinational head read
// ========================================
`timescale 1ns/1ns
`include "issue_params.svh"

module fu_fifo
    import issue_pkg::*;
#(
    parameter int unsigned DEPTH = `ISSUE_FIFO_DEPTH
)(
    input  logic          clk,
    input  logic          reset,

    // ========================================
    // Steerer side
    // ========================================
    // Write strobe arrives only when a slot is free
    input  logic          wr_en_i,
    input  issue_packet_t wr_pkt_i,
    output slot_cnt_t     free_slots_o,

    // ========================================
    // Functional unit side
    // ========================================
    input  logic          rd_en_i,
    output issue_packet_t rd_pkt_o,
    output logic          empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Storage
    issue_packet_t mem [DEPTH];

    // Head is next read, tail is next write
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_raw;
    logic             rd_valid;

    // Pop only when something is there
    assign empty_o  = (count == '0);
    assign rd_valid = rd_en_i && !empty_o;

    // Free space clipped to the lane count
    assign free_raw     = CNT_W'(DEPTH) - count;
    assign free_slots_o = (free_raw >= CNT_W'(`ISSUE_WIDTH)) ? slot_cnt_t'(`ISSUE_WIDTH)
                                                             : slot_cnt_t'(free_raw);

    // ========================================
    // Pointers and occupancy
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (wr_en_i) begin
                // Wrap at DEPTH, works for any depth
                tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (rd_valid) begin
                head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // Read plus write leaves count alone
            case ({wr_en_i, rd_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ========================================
    // Payload
    // ========================================
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[tail] <= wr_pkt_i;
        end
    end

    // Head visible during the read strobe, zero otherwise
    assign rd_pkt_o = rd_valid ? mem[head] : '0;

endmodule

//--- issue_stage.f
+incdir+common
common/issue_pkg.sv
fu_fifo/fu_fifo.sv
source/issue_steer.sv
source/issue_stage.sv
verif/issue_stage_props.sv
verif/issue_stage_tb.sv

//--- source/issue_stage.sv
// ========================================
// Issue stage top level
// Steering block and six unit FIFOs
// ========================================
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_stage
    import issue_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,

    // Issue lanes
    input  logic          [`ISSUE_WIDTH-1:0]  lane_valid_i,
    input  issue_packet_t [`ISSUE_WIDTH-1:0]  lane_pkt_i,
    output logic          [`ISSUE_WIDTH-1:0]  lane_accept_o,

    // Functional unit pull side
    input  logic          [`ISSUE_FU_NUM-1:0] fu_rd_en_i,
    output issue_packet_t [`ISSUE_FU_NUM-1:0] fu_pkt_o,
    output logic          [`ISSUE_FU_NUM-1:0] fu_empty_o
);

    // Steerer to FIFO wiring
    logic          [`ISSUE_FU_NUM-1:0] fu_wr_en;
    issue_packet_t [`ISSUE_FU_NUM-1:0] fu_wr_pkt;
    slot_cnt_t     [`ISSUE_FU_NUM-1:0] fu_free_slots;

    issue_steer steer_i (
        .lane_valid_i    (lane_valid_i),
        .lane_pkt_i      (lane_pkt_i),
        .fu_free_slots_i (fu_free_slots),
        .lane_accept_o   (lane_accept_o),
        .fu_wr_en_o      (fu_wr_en),
        .fu_wr_pkt_o     (fu_wr_pkt)
    );

    // ALU0..2, MUL, LOAD, BRANCH in index order
    for (genvar u = 0; u < `ISSUE_FU_NUM; u++) begin : g_fifo
        fu_fifo #(
            .DEPTH (`ISSUE_FIFO_DEPTH)
        ) fifo_i (
            .clk          (clk),
            .reset        (reset),
            .wr_en_i      (fu_wr_en[u]),
            .wr_pkt_i     (fu_wr_pkt[u]),
            .free_slots_o (fu_free_slots[u]),
            .rd_en_i      (fu_rd_en_i[u]),
            .rd_pkt_o     (fu_pkt_o[u]),
            .empty_o      (fu_empty_o[u])
        );
    end

endmodule

//--- source/issue_steer.sv
// ========================================
// Issue steering
// Decode, ALU balancing, lane arbitration
// ========================================
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_steer
    import issue_pkg::*;
(
    // Lanes from the issuing logic
    input  logic          [`ISSUE_WIDTH-1:0]  lane_valid_i,
    input  issue_packet_t [`ISSUE_WIDTH-1:0]  lane_pkt_i,

    // Room reported by each unit FIFO
    input  slot_cnt_t     [`ISSUE_FU_NUM-1:0] fu_free_slots_i,

    // Same-cycle accept back to the lanes
    output logic          [`ISSUE_WIDTH-1:0]  lane_accept_o,

    // Write side of the unit FIFOs
    output logic          [`ISSUE_FU_NUM-1:0] fu_wr_en_o,
    output issue_packet_t [`ISSUE_FU_NUM-1:0] fu_wr_pkt_o
);

    // ========================================
    // Per-lane decode
    // ========================================
    fu_class_e                                  lane_class [`ISSUE_WIDTH];
    // One-hot target unit of each lane
    logic      [`ISSUE_WIDTH-1:0][`ISSUE_FU_NUM-1:0] lane_tgt;
    // Units actually written by each lane
    logic      [`ISSUE_WIDTH-1:0][`ISSUE_FU_NUM-1:0] lane_wr;
    logic      [`ISSUE_FU_NUM-1:0]              fu_has_room;
    slot_cnt_t [2:0]                            alu_slots;

    // Funct7 only read through the R view
    function automatic fu_class_e decode_class(input instr_word_u instr);
        fu_class_e cls;
        cls = CLASS_ALU;
        case (instr.r_view.opcode)
            OPC_LOAD:   cls = CLASS_LOAD;
            OPC_BRANCH: cls = CLASS_BRANCH;
            OPC_OP: begin
                if (instr.r_view.funct7 == FUNCT7_MULDIV) begin
                    cls = CLASS_MUL;
                end
            end
            // OP-IMM and the rest are plain ALU work
            default:    cls = CLASS_ALU;
        endcase
        return cls;
    endfunction

    // Most free slots wins, ties to the lowest index
    function automatic logic [2:0] pick_alu(
        input slot_cnt_t [2:0] slots,
        input logic      [2:0] avail
    );
        logic [2:0] pick;
        slot_cnt_t  best;
        pick = '0;
        best = '0;
        for (int k = 0; k < 3; k++) begin
            if (avail[k] && ((pick == '0) || (slots[k] > best))) begin
                pick    = '0;
                pick[k] = 1'b1;
                best    = slots[k];
            end
        end
        return pick;
    endfunction

    always_comb begin
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            lane_class[l] = decode_class(lane_pkt_i[l].instr);
        end
    end

    // ALU group view of the free-slot reports
    assign alu_slots[0] = fu_free_slots_i[FU_ALU0];
    assign alu_slots[1] = fu_free_slots_i[FU_ALU1];
    assign alu_slots[2] = fu_free_slots_i[FU_ALU2];

    always_comb begin
        for (int u = 0; u < `ISSUE_FU_NUM; u++) begin
            fu_has_room[u] = (fu_free_slots_i[u] != '0);
        end
    end

    // ========================================
    // Arbitration, lane 0 first
    // ========================================
    always_comb begin
        logic [`ISSUE_FU_NUM-1:0] taken;
        logic [2:0]               alu_oh;
        taken         = '0;
        lane_tgt      = '0;
        lane_wr       = '0;
        lane_accept_o = '0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            // Skip ALUs already claimed by an earlier lane
            alu_oh = pick_alu(alu_slots, ~{taken[FU_ALU2], taken[FU_ALU1], taken[FU_ALU0]});
            case (lane_class[l])
                CLASS_MUL:    lane_tgt[l][FU_MUL]    = 1'b1;
                CLASS_LOAD:   lane_tgt[l][FU_LOAD]   = 1'b1;
                CLASS_BRANCH: lane_tgt[l][FU_BRANCH] = 1'b1;
                default: begin
                    lane_tgt[l][FU_ALU0] = alu_oh[0];
                    lane_tgt[l][FU_ALU1] = alu_oh[1];
                    lane_tgt[l][FU_ALU2] = alu_oh[2];
                end
            endcase
            // Target must have room and be free this cycle
            lane_accept_o[l] = lane_valid_i[l] && |(lane_tgt[l] & fu_has_room & ~taken);
            if (lane_accept_o[l]) begin
                lane_wr[l] = lane_tgt[l];
                taken      = taken | lane_tgt[l];
            end
        end
    end

    // ========================================
    // Write strobes and packet routing
    // ========================================
    always_comb begin
        fu_wr_en_o  = '0;
        fu_wr_pkt_o = '0;
        for (int l = 0; l < `ISSUE_WIDTH; l++) begin
            fu_wr_en_o = fu_wr_en_o | lane_wr[l];
            for (int u = 0; u < `ISSUE_FU_NUM; u++) begin
                // At most one lane hits a given unit
                if (lane_wr[l][u]) begin
                    fu_wr_pkt_o[u] = lane_pkt_i[l];
                end
            end
        end
    end

endmodule

//--- verif/issue_stage_props.sv
// ========================================
// Issue stage invariants
// FIFO write room, lane mapping, read data
// ========================================
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_stage_props
    import issue_pkg::*;
(
    input logic                              clk,
    input logic                              reset,
    input logic          [`ISSUE_WIDTH-1:0]  lane_valid_i,
    input logic          [`ISSUE_WIDTH-1:0]  lane_accept_o,
    input logic          [`ISSUE_FU_NUM-1:0] fu_wr_en,
    input slot_cnt_t     [`ISSUE_FU_NUM-1:0] fu_free_slots,
    input issue_packet_t [`ISSUE_FU_NUM-1:0] fu_pkt_o,
    input logic          [`ISSUE_FU_NUM-1:0] fu_empty_o
);

    for (genvar u = 0; u < `ISSUE_FU_NUM; u++) begin : g_unit
        // Steerer only writes where there is room
        a_no_write_full: assert property (@(posedge clk) disable iff (reset)
            fu_wr_en[u] |-> (fu_free_slots[u] != '0))
            else $error("write strobe on unit FIFO %0d with no free slot", u);

        // Empty FIFO drives a zero packet
        a_empty_zero: assert property (@(posedge clk) disable iff (reset)
            fu_empty_o[u] |-> (fu_pkt_o[u] == '0))
            else $error("unit FIFO %0d is empty but shows a packet", u);
    end

    // Two lanes on one unit would show fewer writes than accepts
    a_one_lane_per_unit: assert property (@(posedge clk) disable iff (reset)
        $countones(fu_wr_en) == $countones(lane_accept_o))
        else $error("write strobes do not match accepted lanes");

    a_accept_valid: assert property (@(posedge clk) disable iff (reset)
        (lane_accept_o & ~lane_valid_i) == '0)
        else $error("lane accepted without a valid packet");

endmodule

// Attached to the top level, which joins steerer and FIFOs
bind issue_stage issue_stage_props props_i (
    .clk           (clk),
    .reset         (reset),
    .lane_valid_i  (lane_valid_i),
    .lane_accept_o (lane_accept_o),
    .fu_wr_en      (fu_wr_en),
    .fu_free_slots (fu_free_slots),
    .fu_pkt_o      (fu_pkt_o),
    .fu_empty_o    (fu_empty_o)
);

//--- verif/issue_stage_tb.sv
// ========================================
// Issue stage testbench
// Stimulus, queue model, compare, watchdog
// ========================================
`timescale 1ns/1ns
`include "issue_params.svh"

module issue_stage_tb
    import issue_pkg::*;
;

    // Rough cycle budget of all tests, plus slack
    localparam int TOTAL_CYCLES = 300;
    localparam int MARGIN       = 100;

    logic                              clk;
    logic                              reset;
    logic          [`ISSUE_WIDTH-1:0]  lane_valid;
    issue_packet_t [`ISSUE_WIDTH-1:0]  lane_pkt;
    logic          [`ISSUE_WIDTH-1:0]  lane_accept;
    logic          [`ISSUE_FU_NUM-1:0] fu_rd;
    issue_packet_t [`ISSUE_FU_NUM-1:0] fu_pkt;
    logic          [`ISSUE_FU_NUM-1:0] fu_empty;

    // Model state
    issue_packet_t model_q [`ISSUE_FU_NUM][$];
    logic [`ISSUE_WIDTH-1:0] exp_acc;
    logic check_en;
    int   seed;
    int   checks;
    int   errors;

    issue_stage dut_i (
        .clk           (clk),
        .reset         (reset),
        .lane_valid_i  (lane_valid),
        .lane_pkt_i    (lane_pkt),
        .lane_accept_o (lane_accept),
        .fu_rd_en_i    (fu_rd),
        .fu_pkt_o      (fu_pkt),
        .fu_empty_o    (fu_empty)
    );

    always #20 clk = ~clk;

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_pkt(input string name, input issue_packet_t exp,
                             input issue_packet_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_accept(input logic [`ISSUE_WIDTH-1:0] exp,
                                input logic [`ISSUE_WIDTH-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch at %0t: lane_accept_o expected %b actual %b", $time, exp, act);
        end
    endtask

    task automatic check_empty(input logic [`ISSUE_FU_NUM-1:0] exp,
                               input logic [`ISSUE_FU_NUM-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("mismatch at %0t: fu_empty_o expected %b actual %b", $time, exp, act);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    // Unit index straight from the raw instruction bits
    function automatic int unit_of(input issue_packet_t p);
        logic [31:0] w;
        w = p.instr;
        case (w[6:0])
            7'h03:   return 4;
            7'h63:   return 5;
            7'h33:   return (w[31:25] == 7'h01) ? 3 : 0;
            default: return 0;
        endcase
    endfunction

    // Accepts and targets from the current queue sizes
    function automatic void steer_ref(input logic [1:0] valid, input issue_packet_t [1:0] pkt,
                                      output logic [1:0] acc, output logic [1:0][2:0] tgt);
        int free [`ISSUE_FU_NUM];
        logic [`ISSUE_FU_NUM-1:0] used;
        int pick;
        for (int u = 0; u < `ISSUE_FU_NUM; u++) begin
            free[u] = `ISSUE_FIFO_DEPTH - model_q[u].size();
            if (free[u] > `ISSUE_WIDTH) free[u] = `ISSUE_WIDTH;
        end
        used = '0;
        acc  = '0;
        tgt  = '0;
        for (int l = 0; l < 2; l++) begin
            pick = unit_of(pkt[l]);
            if (pick == 0) begin
                // Best free ALU, lowest index on ties, skip lane 0's
                pick = -1;
                for (int a = 0; a < 3; a++) begin
                    if (!used[a] && (pick < 0 || free[a] > free[pick])) pick = a;
                end
            end
            tgt[l] = 3'(pick);
            acc[l] = valid[l] && (free[pick] > 0) && !used[pick];
            if (acc[l]) used[pick] = 1'b1;
        end
    endfunction

    // Compare mid-cycle, then advance the model past the next edge
    always @(negedge clk) begin
        logic [1:0]               acc;
        logic [1:0][2:0]          tgt;
        logic [`ISSUE_FU_NUM-1:0] exp_empty;
        issue_packet_t            exp_pkt;
        if (check_en) begin
            steer_ref(lane_valid, lane_pkt, acc, tgt);
            check_accept(acc, lane_accept);
            for (int u = 0; u < `ISSUE_FU_NUM; u++) begin
                exp_empty[u] = (model_q[u].size() == 0);
                exp_pkt = (fu_rd[u] && !exp_empty[u]) ? model_q[u][0] : '0;
                check_pkt($sformatf("fu_pkt_o[%0d]", u), exp_pkt, fu_pkt[u]);
            end
            check_empty(exp_empty, fu_empty);
            for (int u = 0; u < `ISSUE_FU_NUM; u++) begin
                if (fu_rd[u] && !exp_empty[u]) void'(model_q[u].pop_front());
            end
            for (int l = 0; l < 2; l++) begin
                if (acc[l]) model_q[tgt[l]].push_back(lane_pkt[l]);
            end
            exp_acc = acc;
        end
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    // Kind 0 LOAD, 1 BRANCH, 2 MUL, 3 OP, 4 OP-IMM with imm top bits 1
    function automatic issue_packet_t make_pkt(input int kind);
        issue_packet_t p;
        p.pc      = $random(seed);
        p.rob_tag = 5'($random(seed));
        p.instr   = 32'($random(seed));
        case (kind)
            0: p.instr.r_view.opcode = 7'h03;
            1: p.instr.r_view.opcode = 7'h63;
            2: begin
                p.instr.r_view.opcode = 7'h33;
                p.instr.r_view.funct7 = 7'h01;
            end
            3: begin
                p.instr.r_view.opcode = 7'h33;
                p.instr.r_view.funct7 = 7'h00;
            end
            default: begin
                p.instr.i_view.opcode       = 7'h13;
                p.instr.i_view.imm12[11:5] = 7'h01;
            end
        endcase
        return p;
    endfunction

    function automatic int rand_kind();
        return int'($unsigned($random(seed)) % 5);
    endfunction

    // Rejected lanes re-offer, idle lanes take a new packet if wanted
    task automatic offer_cycle(input logic [1:0] want, input int kind0, input int kind1,
                               input logic [`ISSUE_FU_NUM-1:0] rd);
        logic [1:0]          valid;
        issue_packet_t [1:0] pkt;
        int                  kind [2];
        kind[0] = kind0;
        kind[1] = kind1;
        @(posedge clk);
        for (int l = 0; l < 2; l++) begin
            if (lane_valid[l] && !exp_acc[l]) begin
                valid[l] = 1'b1;
                pkt[l]   = lane_pkt[l];
            end else if (want[l]) begin
                valid[l] = 1'b1;
                pkt[l]   = make_pkt(kind[l]);
            end else begin
                valid[l] = 1'b0;
                pkt[l]   = '0;
            end
        end
        lane_valid <= valid;
        lane_pkt   <= pkt;
        fu_rd      <= rd;
    endtask

    task automatic drain(input int n);
        repeat (n) offer_cycle(2'b00, 0, 0, '1);
    endtask

    task automatic end_test(input int n, input string name);
        $display("test %0d %s finished, errors so far %0d", n, name, errors);
    endtask

    // ========================================
    // Tests
    // ========================================
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        lane_valid = '0;
        lane_pkt   = '0;
        fu_rd      = '0;
        exp_acc    = '0;
        check_en   = 1'b0;
        checks     = 0;
        errors     = 0;
        seed       = 32'h4d4d_dc81;
        repeat (16) @(posedge clk);
        reset    <= 1'b0;
        check_en <= 1'b1;

        // Reads on empty FIFOs
        repeat (3) offer_cycle(2'b00, 0, 0, '1);
        @(negedge clk);
        check_empty('1, fu_empty);
        end_test(1, "reset and empty reads");

        // One of each kind on lane 0, two ALU ops share ALU0
        for (int k = 0; k < 5; k++) offer_cycle(2'b01, k, 0, '0);
        offer_cycle(2'b00, 0, 0, '0);
        @(negedge clk);
        check_empty(6'b000110, fu_empty);
        drain(10);
        end_test(2, "decode");

        // ALU pairs with no reads until all three are full
        repeat (8) offer_cycle(2'b11, 3, 3, '0);
        @(negedge clk);
        check_accept(2'b00, lane_accept);
        check_empty(6'b111000, fu_empty);
        drain(10);
        end_test(3, "ALU balancing");

        // Two MULs at once, then fill and release one slot
        offer_cycle(2'b11, 2, 2, '0);
        @(negedge clk);
        check_accept(2'b01, lane_accept);
        repeat (6) offer_cycle(2'b01, 2, 2, '0);
        @(negedge clk);
        check_accept(2'b00, lane_accept);
        offer_cycle(2'b01, 2, 2, 6'b001000);
        @(negedge clk);
        check_accept(2'b00, lane_accept);
        offer_cycle(2'b01, 2, 2, '0);
        @(negedge clk);
        check_accept(2'b01, lane_accept);
        drain(10);
        end_test(4, "conflict and back-pressure");

        // Random mix on both lanes and all read strobes
        repeat (200) begin
            offer_cycle(2'($random(seed)), rand_kind(), rand_kind(),
                        6'($random(seed)));
        end
        drain(10);
        @(negedge clk);
        check_empty('1, fu_empty);
        end_test(5, "random traffic");

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN) * 40);
        $display("timeout: tests did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
